// File: Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert --timescale 1ns/1ns
TOP   := ex_unit_tb
FLIST := all.f
OBJ   := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: all.f
src/ex_pkg.sv
src/ialu.sv
src/ibr.sv
src/ex_retire.sv
src/ex_unit.sv
verification/ex_checker.sv
verification/ex_unit_tb.sv

// File: src/ex_pkg.sv
`default_nettype none

package ex_pkg;

    // Datapath widths
    localparam int XLEN    = 64;
    localparam int PADDR_W = 40;

    // Shift amount comes from the low bits of operand 2
    localparam int SHAMT_W = 6;

    // Register index width
    localparam int REG_W   = 5;

    // Basic scalar types
    typedef logic [XLEN-1:0]    t_rv_reg_data;
    typedef logic [PADDR_W-1:0] t_paddr;
    typedef logic [REG_W-1:0]   t_rv_reg;

    // Sequential fetch step of the not-taken prediction
    localparam t_paddr PC_STEP = 'd4;

    // Which execute unit takes the micro-op
    typedef enum logic [1:0] {
        U_NOP = 2'd0,
        U_ALU = 2'd1,
        U_BR  = 2'd2
    } t_uop;

    // Branch conditions, same codes as RISC-V funct3
    typedef enum logic [2:0] {
        RV_BR_BEQ  = 3'b000,
        RV_BR_BNE  = 3'b001,
        RV_BR_BLT  = 3'b100,
        RV_BR_BGE  = 3'b101,
        RV_BR_BLTU = 3'b110,
        RV_BR_BGEU = 3'b111
    } t_rv_br;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } t_alu_op;

    // One micro-op from issue
    typedef struct packed {
        // Whole micro-op qualifier
        logic         valid;
        t_uop         uop;
        t_paddr       pc;
        // Already sign-extended by decode
        t_rv_reg_data imm64;
        t_rv_br       br_op;
        t_alu_op      alu_op;
        // Operand 2 from imm64 instead of rs2
        logic         use_imm;
        t_rv_reg      rd;
    } t_uinstr;

    // One register write-back
    typedef struct packed {
        logic         valid;
        t_rv_reg      rd;
        t_rv_reg_data data;
    } t_ex_result;

    // Fetch redirect on a mispredicted branch
    typedef struct packed {
        logic   valid;
        t_paddr tgt;
    } t_redirect;

endpackage

`default_nettype wire

// File: src/ex_retire.sv
`timescale 1ns/1ns
`default_nettype none

module ex_retire (
    input  logic               clk,
    input  logic               rst_n,

    input  ex_pkg::t_ex_result alu_result_ex0,
    input  logic               resvld_br_ex0,
    input  logic               br_mispred_ex0,
    input  ex_pkg::t_paddr     br_tgt_ex0,

    output ex_pkg::t_ex_result result_ex1,
    output ex_pkg::t_redirect  redirect_ex1
);

    import ex_pkg::*;

    // Next EX1 contents
    t_ex_result result_d;
    t_redirect  redirect_d;

    // Wrong-path marker for the EX0 slot
    logic squash_ex0;

    // Instruction behind a redirect came from the predicted path
    always_comb squash_ex0 = redirect_ex1.valid;

    // Write-back candidate
    always_comb begin
        result_d       = alu_result_ex0;
        result_d.valid = alu_result_ex0.valid && !squash_ex0;
    end

    // Redirect only on a live mispredicted branch
    always_comb begin
        redirect_d.valid = resvld_br_ex0 && br_mispred_ex0 && !squash_ex0;
        redirect_d.tgt   = br_tgt_ex0;
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_ex1.valid   <= 1'b0;
            redirect_ex1.valid <= 1'b0;
        end else begin
            result_ex1.valid   <= result_d.valid;
            redirect_ex1.valid <= redirect_d.valid;
        end
    end

    // Write-back and redirect payload
    always_ff @(posedge clk) begin
        result_ex1.rd    <= result_d.rd;
        result_ex1.data  <= result_d.data;
        redirect_ex1.tgt <= redirect_d.tgt;
    end

    // ALU and branch units never claim the same micro-op
    a_one_outcome: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(result_ex1.valid && redirect_ex1.valid)
    ) else $error("ex_retire: result and redirect valid together");

endmodule

`default_nettype wire

// File: src/ex_unit.sv
`timescale 1ns/1ns
`default_nettype none

module ex_unit (
    input  logic                 clk,
    input  logic                 rst_n,

    input  ex_pkg::t_uinstr      uinstr_ex0,
    input  ex_pkg::t_rv_reg_data src1val_ex0,
    input  ex_pkg::t_rv_reg_data src2val_ex0,

    output ex_pkg::t_ex_result   result_ex1,
    output ex_pkg::t_redirect    redirect_ex1
);

    import ex_pkg::*;

    // Branch unit outputs
    logic       resvld_br_ex0;
    t_paddr     br_tgt_ex0;
    logic       br_mispred_ex0;

    // ALU write-back
    t_ex_result alu_result_ex0;

    // Branch resolve in EX0
    ibr ibr_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .uinstr_ex0     (uinstr_ex0),
        .src1val_ex0    (src1val_ex0),
        .src2val_ex0    (src2val_ex0),
        .resvld_br_ex0  (resvld_br_ex0),
        .br_tgt_ex0     (br_tgt_ex0),
        .br_mispred_ex0 (br_mispred_ex0)
    );

    // Integer ALU in EX0
    ialu ialu_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .uinstr_ex0     (uinstr_ex0),
        .src1val_ex0    (src1val_ex0),
        .src2val_ex0    (src2val_ex0),
        .alu_result_ex0 (alu_result_ex0)
    );

    // EX1 register and wrong-path squash
    ex_retire ex_retire_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_result_ex0 (alu_result_ex0),
        .resvld_br_ex0  (resvld_br_ex0),
        .br_mispred_ex0 (br_mispred_ex0),
        .br_tgt_ex0     (br_tgt_ex0),
        .result_ex1     (result_ex1),
        .redirect_ex1   (redirect_ex1)
    );

endmodule

`default_nettype wire

// File: src/ialu.sv
`timescale 1ns/1ns
`default_nettype none

module ialu (
    input  logic                 clk,
    input  logic                 rst_n,

    input  ex_pkg::t_uinstr      uinstr_ex0,
    input  ex_pkg::t_rv_reg_data src1val_ex0,
    input  ex_pkg::t_rv_reg_data src2val_ex0,

    output ex_pkg::t_ex_result   alu_result_ex0
);

    import ex_pkg::*;

    // Operands
    t_rv_reg_data op1_ex0;
    t_rv_reg_data op2_ex0;
    logic [SHAMT_W-1:0] shamt_ex0;

    // Compare results
    logic slt_ex0;
    logic sltu_ex0;

    // Raw ALU output
    t_rv_reg_data data_ex0;

    // Operand 2 from register or immediate
    always_comb begin
        op1_ex0 = src1val_ex0;
        op2_ex0 = uinstr_ex0.use_imm ? uinstr_ex0.imm64 : src2val_ex0;
    end

    // RV64 shifts take 6 bits
    always_comb shamt_ex0 = op2_ex0[SHAMT_W-1:0];

    // Signed and unsigned less-than
    always_comb begin
        slt_ex0  = $signed(op1_ex0) < $signed(op2_ex0);
        sltu_ex0 = op1_ex0 < op2_ex0;
    end

    always_comb begin
        case (uinstr_ex0.alu_op)
            ALU_ADD:  data_ex0 = op1_ex0 + op2_ex0;
            ALU_SUB:  data_ex0 = op1_ex0 - op2_ex0;
            ALU_AND:  data_ex0 = op1_ex0 & op2_ex0;
            ALU_OR:   data_ex0 = op1_ex0 | op2_ex0;
            ALU_XOR:  data_ex0 = op1_ex0 ^ op2_ex0;
            // Compares return 0 or 1
            ALU_SLT:  data_ex0 = {{(XLEN-1){1'b0}}, slt_ex0};
            ALU_SLTU: data_ex0 = {{(XLEN-1){1'b0}}, sltu_ex0};
            ALU_SLL:  data_ex0 = op1_ex0 << shamt_ex0;
            ALU_SRL:  data_ex0 = op1_ex0 >> shamt_ex0;
            // Arithmetic shift keeps the sign
            ALU_SRA:  data_ex0 = t_rv_reg_data'($signed(op1_ex0) >>> shamt_ex0);
            default:  data_ex0 = '0;
        endcase
    end

    // Write-back only for a live ALU micro-op
    always_comb begin
        alu_result_ex0.valid = uinstr_ex0.valid && (uinstr_ex0.uop == U_ALU);
        alu_result_ex0.rd    = uinstr_ex0.rd;
        alu_result_ex0.data  = data_ex0;
    end

    // Decode must never send an unknown op to the ALU
    a_alu_op_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        alu_result_ex0.valid |-> uinstr_ex0.alu_op inside {
            ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
            ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
        }
    ) else $error("ialu: illegal alu_op %0h", uinstr_ex0.alu_op);

endmodule

`default_nettype wire

// File: src/ibr.sv
`timescale 1ns/1ns
`default_nettype none

module ibr (
    input  logic                 clk,
    input  logic                 rst_n,

    input  ex_pkg::t_uinstr      uinstr_ex0,
    input  ex_pkg::t_rv_reg_data src1val_ex0,
    input  ex_pkg::t_rv_reg_data src2val_ex0,

    output logic                 resvld_br_ex0,
    output ex_pkg::t_paddr       br_tgt_ex0,
    output logic                 br_mispred_ex0
);

    import ex_pkg::*;

    // Candidate targets
    t_paddr pcnxt_ex0;
    t_paddr tkn_tgt_ex0;
    t_paddr tru_tgt_ex0;

    // Condition result
    logic   tkn_ex0;

    // Live branch micro-op
    always_comb resvld_br_ex0 = uinstr_ex0.valid && (uinstr_ex0.uop == U_BR);

    // Fall-through is what fetch assumed
    always_comb pcnxt_ex0   = uinstr_ex0.pc + PC_STEP;
    // Offset wraps within the physical address space
    always_comb tkn_tgt_ex0 = uinstr_ex0.pc + uinstr_ex0.imm64[PADDR_W-1:0];

    always_comb begin
        case (uinstr_ex0.br_op)
            RV_BR_BEQ:  tkn_ex0 = src1val_ex0 == src2val_ex0;
            RV_BR_BNE:  tkn_ex0 = src1val_ex0 != src2val_ex0;
            // Full-width signed compares
            RV_BR_BLT:  tkn_ex0 = $signed(src1val_ex0) <  $signed(src2val_ex0);
            RV_BR_BGE:  tkn_ex0 = $signed(src1val_ex0) >= $signed(src2val_ex0);
            RV_BR_BLTU: tkn_ex0 = src1val_ex0 <  src2val_ex0;
            RV_BR_BGEU: tkn_ex0 = src1val_ex0 >= src2val_ex0;
            default:    tkn_ex0 = 1'b0;
        endcase
    end

    // Resolved next PC
    always_comb tru_tgt_ex0 = tkn_ex0 ? tkn_tgt_ex0 : pcnxt_ex0;

    // Taken to pc+4 is not a mispredict
    always_comb br_mispred_ex0 = resvld_br_ex0 && (tru_tgt_ex0 != pcnxt_ex0);
    always_comb br_tgt_ex0     = tru_tgt_ex0;

    // Funct3 010 and 011 are not branches
    a_br_op_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        resvld_br_ex0 |-> uinstr_ex0.br_op inside {
            RV_BR_BEQ, RV_BR_BNE, RV_BR_BLT, RV_BR_BGE, RV_BR_BLTU, RV_BR_BGEU
        }
    ) else $error("ibr: illegal br_op %0h", uinstr_ex0.br_op);

endmodule

`default_nettype wire

// File: verification/ex_checker.sv
`timescale 1ns/1ns
`default_nettype none

module ex_checker (
    input  logic               clk,

    // Expected pair for the row now at EX0
    input  logic               chk_en,
    input  int                 test_id,
    input  ex_pkg::t_ex_result exp_result,
    input  ex_pkg::t_redirect  exp_redirect,

    // DUT outputs in EX1
    input  ex_pkg::t_ex_result result_ex1,
    input  ex_pkg::t_redirect  redirect_ex1,

    output int                 pass_count,
    output int                 fail_count
);

    import ex_pkg::*;

    // Row waiting for its EX1 cycle
    logic       pend_en;
    int         pend_id;
    t_ex_result pend_res;
    t_redirect  pend_rdr;

    // Both sides are stable at the falling edge
    initial begin
        string msg;
        pass_count = 0;
        fail_count = 0;
        pend_en    = 1'b0;
        pend_id    = 0;
        pend_res   = '0;
        pend_rdr   = '0;
        forever begin
            @(negedge clk);
            if (pend_en) begin
                msg = "";
                // Payload only matters under an expected valid
                if (result_ex1.valid !== pend_res.valid) begin
                    msg = {msg, $sformatf(" result valid %0b, expected %0b",
                                          result_ex1.valid, pend_res.valid)};
                end else if (pend_res.valid && (result_ex1.rd !== pend_res.rd ||
                                                result_ex1.data !== pend_res.data)) begin
                    msg = {msg, $sformatf(" result rd %0d data %h, expected rd %0d data %h",
                                          result_ex1.rd, result_ex1.data,
                                          pend_res.rd, pend_res.data)};
                end
                if (redirect_ex1.valid !== pend_rdr.valid) begin
                    msg = {msg, $sformatf(" redirect valid %0b, expected %0b",
                                          redirect_ex1.valid, pend_rdr.valid)};
                end else if (pend_rdr.valid && redirect_ex1.tgt !== pend_rdr.tgt) begin
                    msg = {msg, $sformatf(" redirect tgt %h, expected %h",
                                          redirect_ex1.tgt, pend_rdr.tgt)};
                end
                if (msg == "") begin
                    pass_count++;
                    $display("Test %0d ok", pend_id);
                end else begin
                    fail_count++;
                    $display("Fail at %0t ns: test %0d%s", $time, pend_id, msg);
                end
            end
            // Hold this cycle's row until its result is registered
            pend_en  = chk_en;
            pend_id  = test_id;
            pend_res = exp_result;
            pend_rdr = exp_redirect;
        end
    end

endmodule

`default_nettype wire

// File: verification/ex_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ex_unit_tb;

    import ex_pkg::*;

    localparam int RESET_CYCLES  = 3;
    localparam int MARGIN_CYCLES = 10;
    localparam int RND_SEED      = 32'h7715;

    // Operand patterns
    localparam t_rv_reg_data PAT_A = 64'hF0F0_F0F0_F0F0_F0F0;
    localparam t_rv_reg_data PAT_B = 64'hFF00_FF00_FF00_FF00;
    localparam t_rv_reg_data MSB   = 64'h8000_0000_0000_0000;

    // Stimulus and what EX1 shows one cycle later
    typedef struct packed {
        t_uinstr      ui;
        t_rv_reg_data src1;
        t_rv_reg_data src2;
        t_ex_result   exp_res;
        t_redirect    exp_rdr;
        // Both operands get one random value
        logic         rnd;
    } t_row;

    logic         clk;
    logic         rst_n;
    t_uinstr      uinstr_ex0;
    t_rv_reg_data src1val_ex0;
    t_rv_reg_data src2val_ex0;
    t_ex_result   result_ex1;
    t_redirect    redirect_ex1;

    // Checker side
    logic       chk_en;
    int         test_id;
    t_ex_result exp_result;
    t_redirect  exp_redirect;
    int         pass_count;
    int         fail_count;

    t_row table_q[$];
    logic table_ready;

    ex_unit ex_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .uinstr_ex0   (uinstr_ex0),
        .src1val_ex0  (src1val_ex0),
        .src2val_ex0  (src2val_ex0),
        .result_ex1   (result_ex1),
        .redirect_ex1 (redirect_ex1)
    );

    ex_checker ex_checker_i (
        .clk          (clk),
        .chk_en       (chk_en),
        .test_id      (test_id),
        .exp_result   (exp_result),
        .exp_redirect (exp_redirect),
        .result_ex1   (result_ex1),
        .redirect_ex1 (redirect_ex1),
        .pass_count   (pass_count),
        .fail_count   (fail_count)
    );

    task automatic add_nop();
        t_row row;
        row = '0;
        table_q.push_back(row);
    endtask

    // Register-register ALU op with vld low for a squashed slot
    task automatic add_alu(input t_alu_op op, input t_rv_reg dst, input t_rv_reg_data a,
                           input t_rv_reg_data b, input logic vld, input t_rv_reg_data data);
        t_row row;
        row           = '0;
        row.ui.valid  = 1'b1;
        row.ui.uop    = U_ALU;
        row.ui.alu_op = op;
        row.ui.rd     = dst;
        row.src1      = a;
        row.src2      = b;
        row.exp_res   = '{valid: vld, rd: dst, data: data};
        table_q.push_back(row);
    endtask

    // Immediate form where b is driven but must be ignored
    task automatic add_alui(input t_alu_op op, input t_rv_reg dst, input t_rv_reg_data a,
                            input t_rv_reg_data b, input t_rv_reg_data imm,
                            input t_rv_reg_data data);
        t_row row;
        row            = '0;
        row.ui.valid   = 1'b1;
        row.ui.uop     = U_ALU;
        row.ui.alu_op  = op;
        row.ui.use_imm = 1'b1;
        row.ui.imm64   = imm;
        row.ui.rd      = dst;
        row.src1       = a;
        row.src2       = b;
        row.exp_res    = '{valid: 1'b1, rd: dst, data: data};
        table_q.push_back(row);
    endtask

    task automatic add_br(input t_rv_br op, input t_paddr pc, input t_rv_reg_data imm,
                          input t_rv_reg_data a, input t_rv_reg_data b,
                          input logic rdr, input t_paddr tgt);
        t_row row;
        row           = '0;
        row.ui.valid  = 1'b1;
        row.ui.uop    = U_BR;
        row.ui.br_op  = op;
        row.ui.pc     = pc;
        row.ui.imm64  = imm;
        row.src1      = a;
        row.src2      = b;
        row.exp_rdr   = '{valid: rdr, tgt: tgt};
        table_q.push_back(row);
    endtask

    // Operands of the last row come from $urandom
    task automatic mark_random();
        table_q[table_q.size()-1].rnd = 1'b1;
    endtask

    task automatic build_table();
        // Idle after reset
        add_nop();
        add_nop();
        add_nop();
        // Register-register ops
        add_alu(ALU_ADD,  5'd1,  64'd5,   64'd7,    1'b1, 64'd12);
        add_alu(ALU_ADD,  5'd2,  -64'd1,  64'd1,    1'b1, 64'd0);
        add_alu(ALU_SUB,  5'd3,  64'd5,   64'd7,    1'b1, -64'd2);
        add_alu(ALU_AND,  5'd4,  PAT_A,   PAT_B,    1'b1, 64'hF000_F000_F000_F000);
        add_alu(ALU_OR,   5'd5,  PAT_A,   PAT_B,    1'b1, 64'hFFF0_FFF0_FFF0_FFF0);
        add_alu(ALU_XOR,  5'd6,  PAT_A,   PAT_B,    1'b1, 64'h0FF0_0FF0_0FF0_0FF0);
        add_alu(ALU_SLT,  5'd7,  -64'd1,  64'd1,    1'b1, 64'd1);
        add_alu(ALU_SLTU, 5'd8,  -64'd1,  64'd1,    1'b1, 64'd0);
        add_alu(ALU_SLT,  5'd9,  64'd1,   -64'd1,   1'b1, 64'd0);
        add_alu(ALU_SLTU, 5'd10, 64'd1,   -64'd1,   1'b1, 64'd1);
        add_alu(ALU_SLL,  5'd11, 64'd3,   64'd4,    1'b1, 64'd48);
        // Only 6 bits of shift amount count
        add_alu(ALU_SLL,  5'd12, 64'd3,   64'h44,   1'b1, 64'd48);
        add_alu(ALU_SRL,  5'd13, MSB,     64'd4,    1'b1, 64'h0800_0000_0000_0000);
        add_alu(ALU_SRA,  5'd14, MSB,     64'd4,    1'b1, 64'hF800_0000_0000_0000);
        add_alu(ALU_SRA,  5'd15, 64'h4000_0000_0000_0000, 64'd62, 1'b1, 64'd1);
        add_alu(ALU_XOR,  5'd16, 64'd0,   64'd0,    1'b1, 64'd0);
        mark_random();
        // Immediate forms
        add_alui(ALU_ADD,  5'd17, 64'd100, 64'h1234, -64'd3,  64'd97);
        add_alui(ALU_AND,  5'd18, -64'd1,  64'd0,    64'h7FF, 64'h7FF);
        add_alui(ALU_SLT,  5'd19, -64'd5,  MSB,      -64'd3,  64'd1);
        add_alui(ALU_SRA,  5'd20, -64'd256, 64'd0,   64'd4,   -64'd16);
        add_alui(ALU_SLTU, 5'd21, 64'd5,   64'd0,    -64'd1,  64'd1);
        // Taken branch, squashed slot, then a live op
        add_br(RV_BR_BEQ, 40'h1000, 64'h40, 64'd0, 64'd0, 1'b1, 40'h1040);
        mark_random();
        add_alu(ALU_ADD, 5'd22, 64'd1, 64'd1, 1'b0, 64'd0);
        add_alu(ALU_ADD, 5'd23, 64'd2, 64'd3, 1'b1, 64'd5);
        add_br(RV_BR_BEQ,  40'h1100, 64'h40,   -64'd1, 64'd1,  1'b0, 40'h0);
        add_br(RV_BR_BNE,  40'h2000, -64'd16,  -64'd1, 64'd1,  1'b1, 40'h1FF0);
        add_alu(ALU_OR,  5'd24, 64'd1, 64'd2, 1'b0, 64'd0);
        add_br(RV_BR_BNE,  40'h2100, 64'h40,   64'd5,  64'd5,  1'b0, 40'h0);
        add_br(RV_BR_BLT,  40'h3000, 64'h100,  -64'd1, 64'd1,  1'b1, 40'h3100);
        add_alu(ALU_SUB, 5'd25, 64'd9, 64'd2, 1'b0, 64'd0);
        add_br(RV_BR_BLT,  40'h3100, 64'h40,   64'd1,  -64'd1, 1'b0, 40'h0);
        add_br(RV_BR_BGE,  40'h4000, 64'd8,    64'd1,  -64'd1, 1'b1, 40'h4008);
        add_alu(ALU_ADD, 5'd26, 64'd4, 64'd4, 1'b0, 64'd0);
        add_br(RV_BR_BGE,  40'h4100, 64'h40,   -64'd1, 64'd1,  1'b0, 40'h0);
        add_br(RV_BR_BLTU, 40'h5000, -64'd32,  64'd1,  -64'd1, 1'b1, 40'h4FE0);
        add_alu(ALU_AND, 5'd27, 64'd7, 64'd3, 1'b0, 64'd0);
        add_br(RV_BR_BLTU, 40'h5100, 64'h40,   -64'd1, 64'd1,  1'b0, 40'h0);
        add_br(RV_BR_BGEU, 40'h6000, 64'h800,  -64'd1, 64'd1,  1'b1, 40'h6800);
        add_alu(ALU_XOR, 5'd28, 64'd6, 64'd3, 1'b0, 64'd0);
        add_br(RV_BR_BGEU, 40'h6100, 64'h40,   64'd1,  -64'd1, 1'b0, 40'h0);
        // Taken to pc+4 is what fetch assumed
        add_br(RV_BR_BEQ,  40'h7000, 64'd4,    64'd7,  64'd7,  1'b0, 40'h0);
        add_alu(ALU_ADD, 5'd29, 64'd3, 64'd4, 1'b1, 64'd7);
    endtask

    // Operands random only where the row holds for any value
    task automatic apply_row(input t_row row, input int idx);
        t_rv_reg_data r;
        uinstr_ex0   = row.ui;
        src1val_ex0  = row.src1;
        src2val_ex0  = row.src2;
        if (row.rnd) begin
            r           = {$urandom, $urandom};
            src1val_ex0 = r;
            src2val_ex0 = r;
        end
        exp_result   = row.exp_res;
        exp_redirect = row.exp_rdr;
        test_id      = idx + 1;
        chk_en       = 1'b1;
    endtask

    task automatic drive_idle();
        uinstr_ex0   = '0;
        src1val_ex0  = '0;
        src2val_ex0  = '0;
        exp_result   = '0;
        exp_redirect = '0;
        chk_en       = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycle budget from the table length
    initial begin
        int limit;
        int cycles;
        cycles = 0;
        wait (table_ready === 1'b1);
        limit = table_q.size() + RESET_CYCLES + MARGIN_CYCLES;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: checks not finished after %0d clock cycles", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(RND_SEED));
        table_ready = 1'b0;
        rst_n       = 1'b0;
        test_id     = 0;
        drive_idle();
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // One row per cycle 1 ns after the edge
        foreach (table_q[i]) begin
            apply_row(table_q[i], i);
            @(posedge clk);
            #1;
        end
        drive_idle();
        wait (pass_count + fail_count == table_q.size());
        $display("Checks done: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
